//--- common/bp_pkg.sv
// ==============================
// Shared constants of the gselect predictor
// Counters are plain 2-bit saturating counters, taken when the upper bit is set
// ==============================

package bp_pkg;

	// ==============================
	// Slot width
	// ==============================

	// Fetch and commit both move this many instructions per cycle
	// The RTL spells the four fetch and commit ports out by hand, so this stays at 4
	localparam int LANES = 4;

	// ==============================
	// Saturating counter
	// ==============================

	// Width of one pattern table counter
	localparam int CTR_BITS = 2;

	// Value written by the clearing sweep, weakly not taken
	localparam logic [CTR_BITS-1:0] CTR_RESET = 2'd1;

	// Strongly taken, the counter stops here on further taken outcomes
	localparam logic [CTR_BITS-1:0] CTR_MAX = 2'd3;

	// Strongly not taken, the counter stops here on further not-taken outcomes
	localparam logic [CTR_BITS-1:0] CTR_MIN = 2'd0;

	// Values 0 and 1 predict not taken and values 2 and 3 predict taken
	// Only the upper bit is looked at on the fetch side

endpackage

//--- design/branch_predictor_top.sv
// ==============================
// Four wide gselect branch predictor
// Commit side must respect free_slots, there is no stall
// Predictions and training wait for ready after reset
// ==============================

module branch_predictor_top #(
	parameter int IP_WIDTH      = 32,
	parameter int IP_INDEX_BITS = 7,
	parameter int HIST_BITS     = 2,
	parameter int QUEUE_DEPTH   = 16
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              en,
	input  logic [bp_pkg::LANES-1:0]          commit_valid,
	input  logic [IP_WIDTH-1:0]               commit_ip0,
	input  logic [IP_WIDTH-1:0]               commit_ip1,
	input  logic [IP_WIDTH-1:0]               commit_ip2,
	input  logic [IP_WIDTH-1:0]               commit_ip3,
	input  logic [bp_pkg::LANES-1:0]          commit_taken,
	output logic [$clog2(QUEUE_DEPTH):0]      free_slots,
	input  logic [IP_WIDTH-1:0]               fetch_ip0,
	input  logic [IP_WIDTH-1:0]               fetch_ip1,
	input  logic [IP_WIDTH-1:0]               fetch_ip2,
	input  logic [IP_WIDTH-1:0]               fetch_ip3,
	output logic [bp_pkg::LANES-1:0]          predict_taken,
	output logic                              ready
);

	// Table index is the low address bits joined with the whole history
	localparam int INDEX_BITS = IP_INDEX_BITS + HIST_BITS;

	// ==============================
	// Pipeline wires
	// ==============================

	// Queue head to update stage
	logic                        drain_valid;
	logic [IP_WIDTH-1:0]         drain_ip;
	logic                        drain_taken;

	// Update stage to table
	logic                        wr_en;
	logic [INDEX_BITS-1:0]       wr_index;
	logic [bp_pkg::CTR_BITS-1:0] wr_ctr;
	logic [bp_pkg::CTR_BITS-1:0] upd_ctr;
	logic [HIST_BITS-1:0]        global_hist;

	// Fetch lookup to table
	logic [INDEX_BITS-1:0]       rd_index0;
	logic [INDEX_BITS-1:0]       rd_index1;
	logic [INDEX_BITS-1:0]       rd_index2;
	logic [INDEX_BITS-1:0]       rd_index3;
	logic [bp_pkg::CTR_BITS-1:0] rd_ctr0;
	logic [bp_pkg::CTR_BITS-1:0] rd_ctr1;
	logic [bp_pkg::CTR_BITS-1:0] rd_ctr2;
	logic [bp_pkg::CTR_BITS-1:0] rd_ctr3;

	commit_queue #(
		.IP_WIDTH    (IP_WIDTH),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_commit_queue (
		.clk          (clk),
		.rst          (rst),
		.ready        (ready),
		.commit_valid (commit_valid),
		.commit_ip0   (commit_ip0),
		.commit_ip1   (commit_ip1),
		.commit_ip2   (commit_ip2),
		.commit_ip3   (commit_ip3),
		.commit_taken (commit_taken),
		.free_slots   (free_slots),
		.drain_valid  (drain_valid),
		.drain_ip     (drain_ip),
		.drain_taken  (drain_taken)
	);

	history_update #(
		.IP_WIDTH      (IP_WIDTH),
		.IP_INDEX_BITS (IP_INDEX_BITS),
		.HIST_BITS     (HIST_BITS)
	) u_history_update (
		.clk         (clk),
		.rst         (rst),
		.en          (en),
		.drain_valid (drain_valid),
		.drain_ip    (drain_ip),
		.drain_taken (drain_taken),
		.upd_ctr     (upd_ctr),
		.wr_en       (wr_en),
		.wr_index    (wr_index),
		.wr_ctr      (wr_ctr),
		.global_hist (global_hist)
	);

	// The update read port looks at the same entry the update stage will write
	pattern_table #(
		.INDEX_BITS (INDEX_BITS)
	) u_pattern_table (
		.clk       (clk),
		.rst       (rst),
		.rd_index0 (rd_index0),
		.rd_index1 (rd_index1),
		.rd_index2 (rd_index2),
		.rd_index3 (rd_index3),
		.rd_ctr0   (rd_ctr0),
		.rd_ctr1   (rd_ctr1),
		.rd_ctr2   (rd_ctr2),
		.rd_ctr3   (rd_ctr3),
		.upd_index (wr_index),
		.upd_ctr   (upd_ctr),
		.wr_en     (wr_en),
		.wr_index  (wr_index),
		.wr_ctr    (wr_ctr),
		.ready     (ready)
	);

	fetch_predict #(
		.IP_WIDTH      (IP_WIDTH),
		.IP_INDEX_BITS (IP_INDEX_BITS),
		.HIST_BITS     (HIST_BITS)
	) u_fetch_predict (
		.clk           (clk),
		.rst           (rst),
		.en            (en),
		.ready         (ready),
		.fetch_ip0     (fetch_ip0),
		.fetch_ip1     (fetch_ip1),
		.fetch_ip2     (fetch_ip2),
		.fetch_ip3     (fetch_ip3),
		.global_hist   (global_hist),
		.rd_index0     (rd_index0),
		.rd_index1     (rd_index1),
		.rd_index2     (rd_index2),
		.rd_index3     (rd_index3),
		.rd_ctr0       (rd_ctr0),
		.rd_ctr1       (rd_ctr1),
		.rd_ctr2       (rd_ctr2),
		.rd_ctr3       (rd_ctr3),
		.predict_taken (predict_taken)
	);

endmodule

//--- design/commit_queue.sv
// ==============================
// Resolved branch queue, up to four pushes and one pop per cycle
// The commit side must never offer more valid slots than free_slots
// QUEUE_DEPTH must be a power of two and at least 4
// ==============================

module commit_queue #(
	parameter int IP_WIDTH    = 32,
	parameter int QUEUE_DEPTH = 16
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              ready,
	input  logic [bp_pkg::LANES-1:0]          commit_valid,
	input  logic [IP_WIDTH-1:0]               commit_ip0,
	input  logic [IP_WIDTH-1:0]               commit_ip1,
	input  logic [IP_WIDTH-1:0]               commit_ip2,
	input  logic [IP_WIDTH-1:0]               commit_ip3,
	input  logic [bp_pkg::LANES-1:0]          commit_taken,
	output logic [$clog2(QUEUE_DEPTH):0]      free_slots,
	output logic                              drain_valid,
	output logic [IP_WIDTH-1:0]               drain_ip,
	output logic                              drain_taken
);

	localparam int PTR_BITS = $clog2(QUEUE_DEPTH);

	// Commit addresses gathered into an array so the packing loop can index them
	logic [IP_WIDTH-1:0] slot_ip [bp_pkg::LANES];

	// Queue storage, one address and one outcome per entry
	logic [IP_WIDTH-1:0] queue_ip    [QUEUE_DEPTH];
	logic                queue_taken [QUEUE_DEPTH];

	logic [PTR_BITS-1:0] head;
	logic [PTR_BITS-1:0] tail;
	logic [PTR_BITS:0]   count;

	// Number of valid slots offered this cycle
	logic [PTR_BITS:0]   offer_cnt;

	// Queue position each slot lands in, only meaningful for valid slots
	logic [PTR_BITS-1:0] slot_pos [bp_pkg::LANES];

	logic                pop;

	assign slot_ip[0] = commit_ip0;
	assign slot_ip[1] = commit_ip1;
	assign slot_ip[2] = commit_ip2;
	assign slot_ip[3] = commit_ip3;

	// ==============================
	// Slot compaction
	// ==============================

	// Each valid slot goes to the tail plus the number of valid slots below it
	// This keeps slot order and leaves no holes when the strobes are sparse
	always_comb
	begin
		offer_cnt = '0;
		for (int i = 0; i < bp_pkg::LANES; i++)
		begin
			slot_pos[i] = tail + offer_cnt[PTR_BITS-1:0];
			offer_cnt = offer_cnt + (PTR_BITS+1)'(commit_valid[i]);
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < bp_pkg::LANES; i++)
		begin
			if (commit_valid[i])
			begin
				queue_ip[slot_pos[i]]    <= slot_ip[i];
				queue_taken[slot_pos[i]] <= commit_taken[i];
			end
		end
	end

	// ==============================
	// Pointers and occupancy
	// ==============================

	// Nothing leaves the queue while the pattern table is still being swept
	assign pop = (count != '0) && ready;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap naturally since the depth is a power of two
			tail  <= tail + offer_cnt[PTR_BITS-1:0];
			count <= count + offer_cnt - (PTR_BITS+1)'(pop);
			if (pop)
			begin
				head <= head + 1'b1;
			end
		end
	end

	assign free_slots = (PTR_BITS+1)'(QUEUE_DEPTH) - count;

	// The head entry is presented directly and is taken by the update stage register
	assign drain_valid = pop;
	assign drain_ip    = queue_ip[head];
	assign drain_taken = queue_taken[head];

	// ==============================
	// Checks
	// ==============================

	// The commit side has no stall, so it must watch free_slots itself
	a_no_overflow_offer: assert property (@(posedge clk) disable iff (rst)
		offer_cnt <= free_slots)
		else $error("commit side offered more branches than free slots");

	a_count_in_range: assert property (@(posedge clk) disable iff (rst)
		count <= (PTR_BITS+1)'(QUEUE_DEPTH))
		else $error("queue occupancy above depth");

endmodule

//--- predictor/fetch_predict.sv
// ==============================
// Fetch side lookup for four addresses per cycle
// Predictions are registered, one cycle after the addresses
// ==============================

module fetch_predict #(
	parameter int IP_WIDTH      = 32,
	parameter int IP_INDEX_BITS = 7,
	parameter int HIST_BITS     = 2
) (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  en,
	input  logic                                  ready,
	input  logic [IP_WIDTH-1:0]                   fetch_ip0,
	input  logic [IP_WIDTH-1:0]                   fetch_ip1,
	input  logic [IP_WIDTH-1:0]                   fetch_ip2,
	input  logic [IP_WIDTH-1:0]                   fetch_ip3,
	input  logic [HIST_BITS-1:0]                  global_hist,
	output logic [IP_INDEX_BITS+HIST_BITS-1:0]    rd_index0,
	output logic [IP_INDEX_BITS+HIST_BITS-1:0]    rd_index1,
	output logic [IP_INDEX_BITS+HIST_BITS-1:0]    rd_index2,
	output logic [IP_INDEX_BITS+HIST_BITS-1:0]    rd_index3,
	input  logic [bp_pkg::CTR_BITS-1:0]           rd_ctr0,
	input  logic [bp_pkg::CTR_BITS-1:0]           rd_ctr1,
	input  logic [bp_pkg::CTR_BITS-1:0]           rd_ctr2,
	input  logic [bp_pkg::CTR_BITS-1:0]           rd_ctr3,
	output logic [bp_pkg::LANES-1:0]              predict_taken
);

	// Upper counter bit of each lane, bit i belongs to fetch_ip i
	logic [bp_pkg::LANES-1:0] ctr_taken;

	// Same gselect index layout as the update stage
	assign rd_index0 = {fetch_ip0[IP_INDEX_BITS-1:0], global_hist};
	assign rd_index1 = {fetch_ip1[IP_INDEX_BITS-1:0], global_hist};
	assign rd_index2 = {fetch_ip2[IP_INDEX_BITS-1:0], global_hist};
	assign rd_index3 = {fetch_ip3[IP_INDEX_BITS-1:0], global_hist};

	assign ctr_taken = {rd_ctr3[bp_pkg::CTR_BITS-1], rd_ctr2[bp_pkg::CTR_BITS-1],
	                    rd_ctr1[bp_pkg::CTR_BITS-1], rd_ctr0[bp_pkg::CTR_BITS-1]};

	// Table contents before this edge are used, so a write on the same edge is missed
	// Predictions stay low while disabled or while the sweep is still running
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			predict_taken <= '0;
		end
		else if (en && ready)
		begin
			predict_taken <= ctr_taken;
		end
		else
		begin
			predict_taken <= '0;
		end
	end

endmodule

//--- predictor/history_update.sv
// ==============================
// Update stage, one resolved branch per cycle
// Writes and history shifts happen only while en is high
// ==============================

module history_update #(
	parameter int IP_WIDTH      = 32,
	parameter int IP_INDEX_BITS = 7,
	parameter int HIST_BITS     = 2
) (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  en,
	input  logic                                  drain_valid,
	input  logic [IP_WIDTH-1:0]                   drain_ip,
	input  logic                                  drain_taken,
	input  logic [bp_pkg::CTR_BITS-1:0]           upd_ctr,
	output logic                                  wr_en,
	output logic [IP_INDEX_BITS+HIST_BITS-1:0]    wr_index,
	output logic [bp_pkg::CTR_BITS-1:0]           wr_ctr,
	output logic [HIST_BITS-1:0]                  global_hist
);

	// ==============================
	// Stage register
	// ==============================

	logic                     upd_valid;
	// Only the address bits that reach the index are kept
	logic [IP_INDEX_BITS-1:0] upd_ip_lo;
	logic                     upd_taken;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			upd_valid <= 1'b0;
		end
		else
		begin
			upd_valid <= drain_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		upd_ip_lo <= drain_ip[IP_INDEX_BITS-1:0];
		upd_taken <= drain_taken;
	end

	// ==============================
	// Counter update
	// ==============================

	// Address bits sit above the history bits in the gselect index
	// The history used here is the one in force right now, so back to back
	// drains each see the shift made by the one before
	assign wr_index = {upd_ip_lo, global_hist};

	// Step toward the outcome and hold at either end
	always_comb
	begin
		if (upd_taken)
		begin
			wr_ctr = (upd_ctr == bp_pkg::CTR_MAX) ? upd_ctr : upd_ctr + 1'b1;
		end
		else
		begin
			wr_ctr = (upd_ctr == bp_pkg::CTR_MIN) ? upd_ctr : upd_ctr - 1'b1;
		end
	end

	// With en low the entry is simply dropped
	assign wr_en = upd_valid && en;

	// ==============================
	// Global history
	// ==============================

	// Newest outcome enters at bit 0
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			global_hist <= '0;
		end
		else if (wr_en)
		begin
			global_hist <= (global_hist << 1) | HIST_BITS'(upd_taken);
		end
	end

	// The written counter never jumps more than one step, wrap included
	a_ctr_step: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> (({1'b0, wr_ctr} <= {1'b0, upd_ctr} + 1'b1) &&
		           ({1'b0, upd_ctr} <= {1'b0, wr_ctr} + 1'b1)))
		else $error("counter update moved more than one step");

endmodule

//--- predictor/pattern_table.sv
// ==============================
// Pattern table of saturating counters
// Cleared by a sweep of one entry per cycle after reset, ready marks the end
// Reads are combinational and see a write only after its edge
// ==============================

module pattern_table #(
	parameter int INDEX_BITS = 9
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [INDEX_BITS-1:0]           rd_index0,
	input  logic [INDEX_BITS-1:0]           rd_index1,
	input  logic [INDEX_BITS-1:0]           rd_index2,
	input  logic [INDEX_BITS-1:0]           rd_index3,
	output logic [bp_pkg::CTR_BITS-1:0]     rd_ctr0,
	output logic [bp_pkg::CTR_BITS-1:0]     rd_ctr1,
	output logic [bp_pkg::CTR_BITS-1:0]     rd_ctr2,
	output logic [bp_pkg::CTR_BITS-1:0]     rd_ctr3,
	input  logic [INDEX_BITS-1:0]           upd_index,
	output logic [bp_pkg::CTR_BITS-1:0]     upd_ctr,
	input  logic                            wr_en,
	input  logic [INDEX_BITS-1:0]           wr_index,
	input  logic [bp_pkg::CTR_BITS-1:0]     wr_ctr,
	output logic                            ready
);

	localparam int ENTRIES = 1 << INDEX_BITS;

	logic [bp_pkg::CTR_BITS-1:0] ctr_mem [ENTRIES];

	// Next entry the clearing sweep writes
	logic [INDEX_BITS-1:0] sweep_idx;

	// ==============================
	// Clearing sweep
	// ==============================

	// Ready rises on the same edge that writes the last entry
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sweep_idx <= '0;
			ready     <= 1'b0;
		end
		else if (!ready)
		begin
			sweep_idx <= sweep_idx + 1'b1;
			if (sweep_idx == INDEX_BITS'(ENTRIES - 1))
			begin
				ready <= 1'b1;
			end
		end
	end

	// The sweep owns the write port until ready, update writes are dropped before then
	always_ff @(posedge clk)
	begin
		if (!ready)
		begin
			ctr_mem[sweep_idx] <= bp_pkg::CTR_RESET;
		end
		else if (wr_en)
		begin
			ctr_mem[wr_index] <= wr_ctr;
		end
	end

	// ==============================
	// Read ports
	// ==============================

	// Four fetch ports and one port for the read-modify-write of the update stage
	assign rd_ctr0 = ctr_mem[rd_index0];
	assign rd_ctr1 = ctr_mem[rd_index1];
	assign rd_ctr2 = ctr_mem[rd_index2];
	assign rd_ctr3 = ctr_mem[rd_index3];
	assign upd_ctr = ctr_mem[upd_index];

	// The queue holds its entries back until ready, so no update can arrive early
	a_no_write_before_ready: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> ready)
		else $error("table write issued during clearing sweep");

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the predictor testbench with Verilator, runs it and judges the run from sim.log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --top-module tb_branch_predictor \
	-Mdir obj_dir -o sim_tb -f sources.f > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && { echo "Simulation FAILED"; exit 1; } \
	|| { echo "Simulation passed"; exit 0; }

//--- sources.f
common/bp_pkg.sv
design/commit_queue.sv
predictor/history_update.sv
predictor/pattern_table.sv
predictor/fetch_predict.sv
design/branch_predictor_top.sv
test/tb_branch_predictor.sv

//--- test/tb_branch_predictor.sv
// ==============================
// Testbench for the gselect predictor at its default parameters
// A cycle model runs beside the DUT and outputs are compared on every falling edge
// The commit side never offers more branches than free_slots allows
// ==============================

module tb_branch_predictor;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int IP_WIDTH      = 32;
	localparam int IP_INDEX_BITS = 7;
	localparam int HIST_BITS     = 2;
	localparam int QUEUE_DEPTH   = 16;
	localparam int INDEX_BITS    = IP_INDEX_BITS + HIST_BITS;
	localparam int TABLE_SIZE    = 1 << INDEX_BITS;
	localparam int FREE_BITS     = $clog2(QUEUE_DEPTH) + 1;
	localparam int LANES         = bp_pkg::LANES;
	localparam int CLK_PERIOD    = 100;

	// ==============================
	// Cycle budgets
	// ==============================

	localparam int RESET_CYCLES  = 5;
	localparam int DRAIN_LIMIT   = 40;
	localparam int SPARSE_CYCLES = 200;
	localparam int TRAIN_CYCLES  = 40;
	localparam int OFF_CYCLES    = 120;
	localparam int MIXED_CYCLES  = 2000;
	localparam int TOTAL_CYCLES  = RESET_CYCLES + TABLE_SIZE + 16 + SPARSE_CYCLES
		+ 2 * TRAIN_CYCLES + OFF_CYCLES + MIXED_CYCLES + 8 * (DRAIN_LIMIT + 2);

	// Low address bits of the two trained branches, never produced by the random pool
	localparam logic [IP_WIDTH-1:0] A_IP = 32'h0000_1234;
	localparam logic [IP_WIDTH-1:0] B_IP = 32'h0000_5678;

	logic                  clk;
	logic                  rst;
	logic                  en;
	logic [LANES-1:0]      commit_valid;
	logic [IP_WIDTH-1:0]   commit_ip0;
	logic [IP_WIDTH-1:0]   commit_ip1;
	logic [IP_WIDTH-1:0]   commit_ip2;
	logic [IP_WIDTH-1:0]   commit_ip3;
	logic [LANES-1:0]      commit_taken;
	logic [FREE_BITS-1:0]  free_slots;
	logic [IP_WIDTH-1:0]   fetch_ip0;
	logic [IP_WIDTH-1:0]   fetch_ip1;
	logic [IP_WIDTH-1:0]   fetch_ip2;
	logic [IP_WIDTH-1:0]   fetch_ip3;
	logic [LANES-1:0]      predict_taken;
	logic                  ready;

	// Stimulus for the next edge, put on the pins at the falling edge
	logic                  s_en;
	logic [LANES-1:0]      s_valid;
	logic [LANES-1:0]      s_taken;
	logic [IP_WIDTH-1:0]   s_cip [LANES];
	logic [IP_WIDTH-1:0]   s_fip [LANES];

	// ==============================
	// Reference model state
	// ==============================

	logic [IP_WIDTH-1:0]          mq_ip [$];
	logic                         mq_taken [$];
	logic [bp_pkg::CTR_BITS-1:0]  m_table [TABLE_SIZE];
	logic [HIST_BITS-1:0]         m_hist;
	logic                         m_ready;
	int                           m_sweep;
	logic                         m_upd_valid;
	logic [IP_WIDTH-1:0]          m_upd_ip;
	logic                         m_upd_taken;
	logic [LANES-1:0]             m_pred;

	integer seed;
	int     errors;
	int     checks;
	int     tests;

	branch_predictor_top u_branch_predictor_top (
		.clk           (clk),
		.rst           (rst),
		.en            (en),
		.commit_valid  (commit_valid),
		.commit_ip0    (commit_ip0),
		.commit_ip1    (commit_ip1),
		.commit_ip2    (commit_ip2),
		.commit_ip3    (commit_ip3),
		.commit_taken  (commit_taken),
		.free_slots    (free_slots),
		.fetch_ip0     (fetch_ip0),
		.fetch_ip1     (fetch_ip1),
		.fetch_ip2     (fetch_ip2),
		.fetch_ip3     (fetch_ip3),
		.predict_taken (predict_taken),
		.ready         (ready)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(TOTAL_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", TOTAL_CYCLES);
		$display("Errors found");
		$finish;
	end

	// Counter moves one step toward the outcome and sticks at 0 and 3
	function automatic logic [1:0] step_counter(input logic [1:0] c, input logic taken);
		if (taken)
			return (c == 2'd3) ? c : c + 2'd1;
		return (c == 2'd0) ? c : c - 2'd1;
	endfunction

	// Address bits above the history bits
	function automatic logic [INDEX_BITS-1:0] table_index(input logic [IP_WIDTH-1:0] ip,
		input logic [HIST_BITS-1:0] hist);
		return {ip[IP_INDEX_BITS-1:0], hist};
	endfunction

	// Eight low bit patterns with random upper bits, so table entries get reused
	function automatic logic [IP_WIDTH-1:0] pool_ip();
		logic [31:0] r;
		r = $random(seed);
		return {r[31:7], r[2:0], 4'h5};
	endfunction

	task automatic report_fail(input string msg);
		$display("Fail at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic model_reset();
		mq_ip.delete();
		mq_taken.delete();
		// The sweep leaves every entry weakly not taken
		for (int i = 0; i < TABLE_SIZE; i++)
			m_table[i] = 2'd1;
		m_hist      = '0;
		m_ready     = 1'b0;
		m_sweep     = 0;
		m_upd_valid = 1'b0;
		m_upd_ip    = '0;
		m_upd_taken = 1'b0;
		m_pred      = '0;
	endtask

	// ==============================
	// One rising edge of the model
	// ==============================

	task automatic model_advance();
		logic [INDEX_BITS-1:0] idx;
		// Lookup sees table and history as they were before this edge
		for (int i = 0; i < LANES; i++)
			m_pred[i] = s_en && m_ready && m_table[table_index(s_fip[i], m_hist)][1];
		// Registered branch writes its counter and shifts history, only while enabled
		if (m_upd_valid && s_en)
		begin
			idx = table_index(m_upd_ip, m_hist);
			m_table[idx] = step_counter(m_table[idx], m_upd_taken);
			m_hist = {m_hist[0], m_upd_taken};
		end
		// Oldest entry moves into the update register once the sweep is over
		m_upd_valid = (mq_ip.size() != 0) && m_ready;
		if (m_upd_valid)
		begin
			m_upd_ip    = mq_ip.pop_front();
			m_upd_taken = mq_taken.pop_front();
		end
		// Valid slots enter in slot order
		for (int i = 0; i < LANES; i++)
		begin
			if (s_valid[i])
			begin
				mq_ip.push_back(s_cip[i]);
				mq_taken.push_back(s_taken[i]);
			end
		end
		if (!m_ready)
		begin
			m_ready = (m_sweep == TABLE_SIZE - 1);
			m_sweep++;
		end
	endtask

	task automatic check_outputs();
		logic [FREE_BITS-1:0] exp_free;
		logic                 exp_drain;
		exp_free  = FREE_BITS'(QUEUE_DEPTH - mq_ip.size());
		exp_drain = (mq_ip.size() != 0) && m_ready;
		checks++;
		if (predict_taken !== m_pred)
			report_fail($sformatf("predict_taken %b, expected %b", predict_taken, m_pred));
		if (ready !== m_ready)
			report_fail($sformatf("ready %b, expected %b", ready, m_ready));
		if (free_slots !== exp_free)
			report_fail($sformatf("free_slots %0d, expected %0d", free_slots, exp_free));
		if (u_branch_predictor_top.global_hist !== m_hist)
			report_fail($sformatf("history %b, expected %b",
				u_branch_predictor_top.global_hist, m_hist));
		if (u_branch_predictor_top.drain_valid !== exp_drain)
			report_fail($sformatf("drain_valid %b, expected %b",
				u_branch_predictor_top.drain_valid, exp_drain));
		else if (exp_drain && (u_branch_predictor_top.drain_ip !== mq_ip[0] ||
			u_branch_predictor_top.drain_taken !== mq_taken[0]))
			report_fail($sformatf("queue head %h/%b, expected %h/%b",
				u_branch_predictor_top.drain_ip, u_branch_predictor_top.drain_taken,
				mq_ip[0], mq_taken[0]));
	endtask

	// Called at a falling edge, returns at the next one after checking
	task automatic run_cycle();
		en           = s_en;
		commit_valid = s_valid;
		commit_taken = s_taken;
		commit_ip0   = s_cip[0];
		commit_ip1   = s_cip[1];
		commit_ip2   = s_cip[2];
		commit_ip3   = s_cip[3];
		fetch_ip0    = s_fip[0];
		fetch_ip1    = s_fip[1];
		fetch_ip2    = s_fip[2];
		fetch_ip3    = s_fip[3];
		model_advance();
		@(negedge clk);
		check_outputs();
	endtask

	// Random strobes, trimmed from the top slot down to the room left in the queue
	task automatic random_commits();
		logic [31:0] r;
		int          room;
		int          n;
		room = QUEUE_DEPTH - mq_ip.size();
		r = $random(seed);
		s_valid = r[3:0];
		s_taken = r[7:4];
		n = 0;
		for (int i = 0; i < LANES; i++)
		begin
			s_cip[i] = pool_ip();
			if (s_valid[i] && n >= room)
				s_valid[i] = 1'b0;
			else if (s_valid[i])
				n++;
		end
	endtask

	task automatic random_fetch();
		for (int i = 0; i < LANES; i++)
			s_fip[i] = pool_ip();
	endtask

	task automatic fetch_all(input logic [IP_WIDTH-1:0] ip);
		for (int i = 0; i < LANES; i++)
			s_fip[i] = ip;
	endtask

	task automatic commit_one(input logic [IP_WIDTH-1:0] ip, input logic taken);
		s_valid  = 4'b0001;
		s_taken  = {3'b000, taken};
		s_cip[0] = ip;
		run_cycle();
		s_valid = '0;
	endtask

	// Empty the queue, then two more edges for the last write and the lookup after it
	task automatic drain_queue();
		int n;
		n = 0;
		s_valid = '0;
		while (free_slots !== FREE_BITS'(QUEUE_DEPTH) && n < DRAIN_LIMIT)
		begin
			run_cycle();
			n++;
		end
		if (n >= DRAIN_LIMIT)
		begin
			$display("Timeout: queue did not drain within %0d cycles", DRAIN_LIMIT);
			errors++;
		end
		run_cycle();
		run_cycle();
	endtask

	task automatic compare_table();
		for (int i = 0; i < TABLE_SIZE; i++)
		begin
			if (u_branch_predictor_top.u_pattern_table.ctr_mem[i] !== m_table[i])
				report_fail($sformatf("table entry %0d holds %0d, expected %0d", i,
					u_branch_predictor_top.u_pattern_table.ctr_mem[i], m_table[i]));
		end
	endtask

	task automatic finish_test(input string name, input int start_errors);
		tests++;
		$display("Test %0d %s finished with %0d errors", tests, name, errors - start_errors);
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial
	begin
		int                   n;
		int                   start;
		logic [HIST_BITS-1:0] hist_before;
		logic [31:0]          r;
		seed   = 63682;
		errors = 0;
		checks = 0;
		tests  = 0;
		rst          = 1'b1;
		en           = 1'b0;
		commit_valid = '0;
		commit_taken = '0;
		commit_ip0   = '0;
		commit_ip1   = '0;
		commit_ip2   = '0;
		commit_ip3   = '0;
		fetch_ip0    = '0;
		fetch_ip1    = '0;
		fetch_ip2    = '0;
		fetch_ip3    = '0;
		s_en    = 1'b1;
		s_valid = '0;
		s_taken = '0;
		for (int i = 0; i < LANES; i++)
		begin
			s_cip[i] = '0;
			s_fip[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		model_reset();

		// Sweep length and quiet outputs until ready
		start = errors;
		n = 0;
		while (ready !== 1'b1 && n < TABLE_SIZE + 16)
		begin
			random_fetch();
			run_cycle();
			n++;
			if (predict_taken !== '0)
				report_fail("prediction raised before the sweep ended");
		end
		if (ready !== 1'b1)
		begin
			$display("Timeout: ready never rose after reset");
			errors++;
		end
		else if (n != TABLE_SIZE)
			report_fail($sformatf("sweep took %0d cycles, expected %0d", n, TABLE_SIZE));
		if (free_slots !== FREE_BITS'(QUEUE_DEPTH))
			report_fail($sformatf("free_slots %0d after sweep", free_slots));
		finish_test("reset sweep", start);

		// Sparse strobes fill the queue faster than it drains
		start = errors;
		repeat (SPARSE_CYCLES)
		begin
			random_commits();
			random_fetch();
			run_cycle();
		end
		drain_queue();
		finish_test("queue order", start);

		// Saturation both ways on one address
		start = errors;
		fetch_all(A_IP);
		repeat (6) commit_one(A_IP, 1'b1);
		drain_queue();
		if (predict_taken !== 4'b1111)
			report_fail("address not predicted taken after taken training");
		repeat (6) commit_one(A_IP, 1'b0);
		drain_queue();
		if (predict_taken !== 4'b0000)
			report_fail("address still predicted taken after not-taken training");
		finish_test("saturation", start);

		// Alternating outcomes train two history slots of one address apart
		start = errors;
		fetch_all(B_IP);
		repeat (6)
		begin
			commit_one(B_IP, 1'b1);
			commit_one(B_IP, 1'b0);
		end
		drain_queue();
		if (predict_taken !== 4'b1111)
			report_fail("history 10 should select a taken counter");
		commit_one(B_IP, 1'b1);
		drain_queue();
		if (predict_taken !== 4'b0000)
			report_fail("history 01 should select a not-taken counter");
		finish_test("history select", start);

		// Disabled, entries drain but leave no trace
		start = errors;
		hist_before = u_branch_predictor_top.global_hist;
		s_en = 1'b0;
		repeat (OFF_CYCLES)
		begin
			random_commits();
			random_fetch();
			run_cycle();
			if (predict_taken !== '0)
				report_fail("prediction raised while disabled");
		end
		drain_queue();
		if (u_branch_predictor_top.global_hist !== hist_before)
			report_fail("history moved while disabled");
		compare_table();
		s_en = 1'b1;
		finish_test("disabled", start);

		// Mixed traffic with en dropping now and then
		start = errors;
		repeat (MIXED_CYCLES)
		begin
			r = $random(seed);
			s_en = (r[3:0] != 4'd0);
			random_commits();
			random_fetch();
			run_cycle();
		end
		s_en = 1'b1;
		drain_queue();
		compare_table();
		finish_test("random traffic", start);

		$display("Tests run %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
